/* hw/hash_pkg.sv */
package hash_pkg;

    localparam int KEY_WIDTH   = 8;
    localparam int DATA_WIDTH  = 16;
    localparam int NUM_TABLES  = 2;
    localparam int ADR_WIDTH   = 4;
    localparam int TABLE_DEPTH = 1 << ADR_WIDTH; // entries per table

    typedef logic [KEY_WIDTH-1:0]  key_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADR_WIDTH-1:0]  adr_t;

    // 0 does nothing, as with a dropped valid strobe
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_READ   = 2'd1,
        OP_WRITE  = 2'd2,
        OP_DELETE = 2'd3
    } op_e;

    // one row per key bit
    typedef adr_t [KEY_WIDTH-1:0] h3_matrix_t;

    typedef struct packed {
        logic  valid;
        key_t  key;
        data_t data;
    } entry_t;

    typedef struct packed {
        logic   en;
        adr_t   addr;
        entry_t entry; // valid clear on a delete
    } table_wr_t;

    typedef struct packed {
        op_e                   op;
        key_t                  key;
        data_t                 data;
        adr_t [NUM_TABLES-1:0] adr; // hash address per table
    } op_stage_t;

endpackage

/* hw/h3_hash.sv */
`timescale 1ns/1ps

module h3_hash (
    input  hash_pkg::key_t       key_i,
    input  hash_pkg::h3_matrix_t matrix_i,
    output hash_pkg::adr_t       adr_o
);

    // xor of the rows selected by the set key bits
    always_comb begin
        adr_o = '0;
        for (int i = 0; i < hash_pkg::KEY_WIDTH; i++) begin
            if (key_i[i]) begin
                adr_o = adr_o ^ matrix_i[i];
            end
        end
    end

endmodule

/* hw/bucket_ram.sv */
`timescale 1ns/1ps

module bucket_ram (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                en_i,
    input  hash_pkg::adr_t      rd_adr_i,
    input  hash_pkg::table_wr_t wr_i,
    output hash_pkg::entry_t    entry_o
);

    logic [hash_pkg::KEY_WIDTH+hash_pkg::DATA_WIDTH-1:0] mem [hash_pkg::TABLE_DEPTH];
    logic [hash_pkg::TABLE_DEPTH-1:0]                    valid_q;

    hash_pkg::key_t  rd_key;
    hash_pkg::data_t rd_data;
    logic            rd_valid;

    // key and data, read before write on the same address
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (wr_i.en) begin
                mem[wr_i.addr] <= {wr_i.entry.key, wr_i.entry.data};
            end
            {rd_key, rd_data} <= mem[rd_adr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else if (en_i) begin
            if (wr_i.en) begin
                valid_q[wr_i.addr] <= wr_i.entry.valid;
            end
            rd_valid <= valid_q[rd_adr_i]; // old flag, like the data
        end
    end

    assign entry_o = '{valid: rd_valid, key: rd_key, data: rd_data};

endmodule

/* hw/op_pipe.sv */
`timescale 1ns/1ps

module op_pipe (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    input  logic                                        en_i,
    input  logic                                        valid_i,
    input  hash_pkg::op_e                               op_i,
    input  hash_pkg::key_t                              key_i,
    input  hash_pkg::data_t                             data_i,
    input  hash_pkg::adr_t [hash_pkg::NUM_TABLES-1:0]   adr_i,
    output hash_pkg::op_stage_t                         stage_o
);

    hash_pkg::op_e                             op_q;
    hash_pkg::key_t                            key_q;
    hash_pkg::data_t                           data_q;
    hash_pkg::adr_t [hash_pkg::NUM_TABLES-1:0] adr_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_q <= hash_pkg::OP_NOP;
        end else if (en_i) begin
            op_q <= valid_i ? op_i : hash_pkg::OP_NOP; // no strobe, no op
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            key_q  <= key_i;
            data_q <= data_i;
            adr_q  <= adr_i;
        end
    end

    assign stage_o = '{op: op_q, key: key_q, data: data_q, adr: adr_q};

endmodule

/* hw/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          en_i,
    input  hash_pkg::op_stage_t                           stage_i,
    input  hash_pkg::entry_t    [hash_pkg::NUM_TABLES-1:0] entry_i,
    input  hash_pkg::table_wr_t [hash_pkg::NUM_TABLES-1:0] wr_i,
    output hash_pkg::entry_t    [hash_pkg::NUM_TABLES-1:0] entry_o
);

    hash_pkg::table_wr_t [hash_pkg::NUM_TABLES-1:0] last_wr_q;
    logic                [hash_pkg::NUM_TABLES-1:0] hit_wr;

    // the write issued at the same edge as the ram read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_wr_q <= '0;
        end else if (en_i) begin
            last_wr_q <= wr_i;
        end
    end

    always_comb begin
        for (int t = 0; t < hash_pkg::NUM_TABLES; t++) begin
            hit_wr[t] = last_wr_q[t].en && (last_wr_q[t].addr == stage_i.adr[t]);
            // covers deletes too, their entry has valid low
            entry_o[t] = hit_wr[t] ? last_wr_q[t].entry : entry_i[t];
        end
    end

endmodule

/* hw/hash_controller.sv */
`timescale 1ns/1ps

module hash_controller (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           en_i,
    input  hash_pkg::op_stage_t                            stage_i,
    input  hash_pkg::entry_t    [hash_pkg::NUM_TABLES-1:0] entry_i,
    output hash_pkg::table_wr_t [hash_pkg::NUM_TABLES-1:0] wr_o,
    output logic                                           valid_o,
    output hash_pkg::data_t                                read_data_o,
    output logic                                           no_deletion_target_o,
    output logic                                           no_write_space_o,
    output logic                                           no_element_found_o,
    output logic                                           key_already_present_o
);

    logic [hash_pkg::NUM_TABLES-1:0] hit;
    logic [hash_pkg::NUM_TABLES-1:0] free;
    logic [hash_pkg::NUM_TABLES-1:0] sel_free; // one-hot, lowest free table
    logic                            any_hit;
    logic                            any_free;
    logic                            is_read;
    logic                            is_write;
    logic                            is_delete;
    hash_pkg::data_t                 hit_data;

    assign is_read   = (stage_i.op == hash_pkg::OP_READ);
    assign is_write  = (stage_i.op == hash_pkg::OP_WRITE);
    assign is_delete = (stage_i.op == hash_pkg::OP_DELETE);

    always_comb begin
        sel_free = '0;
        hit_data = '0;
        for (int t = 0; t < hash_pkg::NUM_TABLES; t++) begin
            hit[t]  = entry_i[t].valid && (entry_i[t].key == stage_i.key);
            free[t] = !entry_i[t].valid;
        end
        // walk down so the lowest index wins
        for (int t = hash_pkg::NUM_TABLES - 1; t >= 0; t--) begin
            if (free[t]) begin
                sel_free    = '0;
                sel_free[t] = 1'b1;
            end
            if (hit[t]) begin
                hit_data = entry_i[t].data;
            end
        end
    end

    assign any_hit  = |hit;
    assign any_free = |free;

    // writes go out now, the ram takes them on the result edge
    always_comb begin
        for (int t = 0; t < hash_pkg::NUM_TABLES; t++) begin
            wr_o[t].addr  = stage_i.adr[t];
            wr_o[t].entry = '{valid: is_write, key: stage_i.key, data: stage_i.data};
            wr_o[t].en    = (is_write && !any_hit && sel_free[t]) || (is_delete && hit[t]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o               <= 1'b0;
            no_deletion_target_o  <= 1'b0;
            no_write_space_o      <= 1'b0;
            no_element_found_o    <= 1'b0;
            key_already_present_o <= 1'b0;
        end else if (en_i) begin
            valid_o               <= (stage_i.op != hash_pkg::OP_NOP);
            no_deletion_target_o  <= is_delete && !any_hit;
            no_write_space_o      <= is_write && !any_hit && !any_free;
            no_element_found_o    <= is_read && !any_hit;
            key_already_present_o <= is_write && any_hit; // table left as is
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            read_data_o <= hit_data;
        end
    end

endmodule

/* hw/hash_table.sv */
`timescale 1ns/1ps

module hash_table (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  hash_pkg::h3_matrix_t [hash_pkg::NUM_TABLES-1:0] matrixes_i,
    input  hash_pkg::key_t                                  key_i,
    input  hash_pkg::data_t                                 data_i,
    input  hash_pkg::op_e                                   op_i,
    input  logic                                            valid_i,
    input  logic                                            ready_i,
    output logic                                            valid_o,
    output hash_pkg::data_t                                 read_data_o,
    output logic                                            no_deletion_target_o,
    output logic                                            no_write_space_o,
    output logic                                            no_element_found_o,
    output logic                                            key_already_present_o
);

    hash_pkg::adr_t      [hash_pkg::NUM_TABLES-1:0] hash_adr;
    hash_pkg::entry_t    [hash_pkg::NUM_TABLES-1:0] ram_entry;
    hash_pkg::entry_t    [hash_pkg::NUM_TABLES-1:0] fwd_entry;
    hash_pkg::table_wr_t [hash_pkg::NUM_TABLES-1:0] table_wr;
    hash_pkg::op_stage_t                            stage;

    for (genvar t = 0; t < hash_pkg::NUM_TABLES; t++) begin : g_table
        h3_hash u_hash (
            .key_i    (key_i),
            .matrix_i (matrixes_i[t]),
            .adr_o    (hash_adr[t])
        );

        bucket_ram u_ram (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .en_i     (ready_i),
            .rd_adr_i (hash_adr[t]),
            .wr_i     (table_wr[t]),
            .entry_o  (ram_entry[t])
        );
    end

    op_pipe u_op_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (ready_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .key_i   (key_i),
        .data_i  (data_i),
        .adr_i   (hash_adr),
        .stage_o (stage)
    );

    forward_unit u_forward (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (ready_i),
        .stage_i (stage),
        .entry_i (ram_entry),
        .wr_i    (table_wr),
        .entry_o (fwd_entry)
    );

    hash_controller u_ctrl (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .en_i                  (ready_i),
        .stage_i               (stage),
        .entry_i               (fwd_entry),
        .wr_o                  (table_wr),
        .valid_o               (valid_o),
        .read_data_o           (read_data_o),
        .no_deletion_target_o  (no_deletion_target_o),
        .no_write_space_o      (no_write_space_o),
        .no_element_found_o    (no_element_found_o),
        .key_already_present_o (key_already_present_o)
    );

endmodule

/* bench/hash_table_sva.sv */
`timescale 1ns/1ps

module hash_table_sva (
    input logic clk,
    input logic rst_n_i,
    input logic valid_o,
    input logic no_deletion_target_o,
    input logic no_write_space_o,
    input logic no_element_found_o,
    input logic key_already_present_o
);

    logic [3:0] flags;

    assign flags = {no_deletion_target_o, no_write_space_o,
                    no_element_found_o, key_already_present_o};

    a_one_flag: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(flags))
        else $error("more than one error flag high");

    a_flag_valid: assert property (@(posedge clk) disable iff (!rst_n_i) (|flags) |-> valid_o)
        else $error("error flag without valid_o");

    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !valid_o)
        else $error("valid_o high during reset");

endmodule

bind hash_table hash_table_sva u_sva (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .valid_o               (valid_o),
    .no_deletion_target_o  (no_deletion_target_o),
    .no_write_space_o      (no_write_space_o),
    .no_element_found_o    (no_element_found_o),
    .key_already_present_o (key_already_present_o)
);

/* bench/tb_hash_table.sv */
`timescale 1ns/1ps

module tb_hash_table;

    localparam time         CLK_PERIOD        = 20ns;
    localparam int          RESET_CYCLES      = 16;
    localparam int          RANDOM_OPS        = 200;
    localparam int          TEST_OPS          = RANDOM_OPS + 40;
    localparam int          MAX_CYCLES_PER_OP = 8; // covers op, worst stall and drain
    localparam logic [31:0] MAT0              = 32'hbc638421;
    localparam logic [31:0] MAT1              = 32'h79c61842; // MAT0 rows rotated left

    typedef struct packed {
        logic            nde;
        logic            nws;
        logic            nef;
        logic            kap;
        logic            chk_data;
        hash_pkg::data_t data;
    } expect_t;

    logic                                            clk;
    logic                                            rst_n_i;
    hash_pkg::h3_matrix_t [hash_pkg::NUM_TABLES-1:0] matrixes_i;
    hash_pkg::key_t                                  key_i;
    hash_pkg::data_t                                 data_i;
    hash_pkg::op_e                                   op_i;
    logic                                            valid_i;
    logic                                            ready_i;
    logic                                            valid_o;
    hash_pkg::data_t                                 read_data_o;
    logic                                            no_deletion_target_o;
    logic                                            no_write_space_o;
    logic                                            no_element_found_o;
    logic                                            key_already_present_o;

    logic            m_valid [2][16];
    hash_pkg::key_t  m_key   [2][16];
    hash_pkg::data_t m_data  [2][16];
    expect_t         exp_q[$];
    logic            ready_at_edge;
    integer          seed;

    hash_table dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_now();
        end
    endtask

    function automatic hash_pkg::adr_t h3_addr(hash_pkg::key_t key, int t);
        logic [31:0]    m;
        hash_pkg::adr_t a;
        m = (t == 0) ? MAT0 : MAT1;
        a = '0;
        for (int i = 0; i < 8; i++) begin
            if (key[i]) a = a ^ m[4*i +: 4];
        end
        return a;
    endfunction

    // reference behavior that also updates the model tables
    function automatic expect_t model_op(hash_pkg::op_e op, hash_pkg::key_t key,
                                         hash_pkg::data_t data);
        expect_t        e;
        int             hit_t;
        int             free_t;
        hash_pkg::adr_t a [2];
        e      = '0;
        hit_t  = -1;
        free_t = -1;
        for (int t = 1; t >= 0; t--) begin // lowest table wins
            a[t] = h3_addr(key, t);
            if (m_valid[t][a[t]] && m_key[t][a[t]] == key) hit_t = t;
            if (!m_valid[t][a[t]]) free_t = t;
        end
        case (op)
            hash_pkg::OP_READ: begin
                if (hit_t >= 0) begin
                    e.chk_data = 1'b1;
                    e.data     = m_data[hit_t][a[hit_t]];
                end else e.nef = 1'b1;
            end
            hash_pkg::OP_WRITE: begin
                if (hit_t >= 0) e.kap = 1'b1;
                else if (free_t >= 0) begin
                    m_valid[free_t][a[free_t]] = 1'b1;
                    m_key[free_t][a[free_t]]   = key;
                    m_data[free_t][a[free_t]]  = data;
                end else e.nws = 1'b1;
            end
            hash_pkg::OP_DELETE: begin
                if (hit_t >= 0) m_valid[hit_t][a[hit_t]] = 1'b0;
                else e.nde = 1'b1;
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic drive_op(hash_pkg::op_e op, hash_pkg::key_t key, hash_pkg::data_t data);
        @(negedge clk);
        ready_i = 1'b1;
        valid_i = 1'b1;
        op_i    = op;
        key_i   = key;
        data_i  = data;
        exp_q.push_back(model_op(op, key, data));
    endtask

    task automatic drain();
        int n;
        @(negedge clk);
        ready_i = 1'b1;
        valid_i = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("results still missing after the pipeline drained");
            fail_now();
        end
    endtask

    always @(posedge clk) ready_at_edge <= ready_i;

    // one result per accepted op in order
    always @(negedge clk) begin : monitor
        expect_t e;
        if (rst_n_i && ready_at_edge && valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("valid_o rose with no op outstanding");
                fail_now();
            end
            e = exp_q.pop_front();
            check_val("no_deletion_target_o", 32'(no_deletion_target_o), 32'(e.nde));
            check_val("no_write_space_o", 32'(no_write_space_o), 32'(e.nws));
            check_val("no_element_found_o", 32'(no_element_found_o), 32'(e.nef));
            check_val("key_already_present_o", 32'(key_already_present_o), 32'(e.kap));
            if (e.chk_data) check_val("read_data_o", 32'(read_data_o), 32'(e.data));
        end
    end

    task automatic reset_outputs_low();
        check_val("valid_o", 32'(valid_o), 32'h0);
        check_val("error flags", 32'({no_deletion_target_o, no_write_space_o,
                  no_element_found_o, key_already_present_o}), 32'h0);
    endtask

    task automatic fill_both_slots();
        hash_pkg::key_t base;
        hash_pkg::key_t mates [2];
        int             found;
        base  = 8'h81;
        found = 0;
        for (int k = 0; k < 256 && found < 2; k++) begin
            if (k != int'(base) && h3_addr(8'(k), 0) == h3_addr(base, 0)
                && h3_addr(8'(k), 1) == h3_addr(base, 1)) begin
                mates[found] = 8'(k);
                found++;
            end
        end
        assert (found == 2) else begin
            $display("no three keys share both table addresses");
            fail_now();
        end
        drive_op(hash_pkg::OP_WRITE, base, 16'h0a01);
        drive_op(hash_pkg::OP_WRITE, mates[0], 16'h0a02);
        drive_op(hash_pkg::OP_WRITE, mates[1], 16'h0a03);
        assert (exp_q[$].nws) else begin
            $display("third colliding key did not find both slots taken");
            fail_now();
        end
        // free the shared address again for the later tests
        drive_op(hash_pkg::OP_DELETE, base, 16'h0);
        drive_op(hash_pkg::OP_DELETE, mates[0], 16'h0);
        drain();
    endtask

    task automatic write_and_read_back();
        for (int i = 0; i < 6; i++) begin
            drive_op(hash_pkg::OP_WRITE, 8'(8'h20 + 3 * i), 16'(16'h1000 + i));
        end
        // newest key first so the first read needs the forwarded write
        for (int i = 5; i >= 0; i--) begin
            drive_op(hash_pkg::OP_READ, 8'(8'h20 + 3 * i), 16'h0);
        end
        drain();
    endtask

    task automatic rewrite_present_key();
        drive_op(hash_pkg::OP_WRITE, 8'h20, 16'hbeef);
        drive_op(hash_pkg::OP_READ, 8'h20, 16'h0);
        drain();
    endtask

    task automatic delete_and_miss();
        drive_op(hash_pkg::OP_WRITE, 8'h55, 16'h5555);
        drive_op(hash_pkg::OP_DELETE, 8'h55, 16'h0);
        assert (!exp_q[$].nde) else begin
            $display("the key to delete was never stored");
            fail_now();
        end
        drive_op(hash_pkg::OP_READ, 8'h55, 16'h0);
        drive_op(hash_pkg::OP_DELETE, 8'h56, 16'h0);
        drain();
    endtask

    task automatic random_ops_with_stalls();
        int r;
        int opn;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            if (r[3:2] == 2'b00) begin
                repeat (1 + r[6:5]) begin // frozen pipeline
                    @(negedge clk);
                    ready_i = 1'b0;
                    valid_i = r[4];
                end
            end
            opn = 1 + int'({$random(seed)} % 3);
            drive_op(hash_pkg::op_e'(opn[1:0]), 8'({$random(seed)} % 24), 16'($random(seed)));
        end
        drain();
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_OPS * MAX_CYCLES_PER_OP));
        $display("timeout, the tests did not finish in time");
        fail_now();
    end

    initial begin
        seed          = 32'ha5c5;
        rst_n_i       = 1'b0;
        ready_i       = 1'b0;
        valid_i       = 1'b0;
        ready_at_edge = 1'b0;
        op_i          = hash_pkg::OP_NOP;
        key_i         = '0;
        data_i        = '0;
        matrixes_i    = {MAT1, MAT0};
        for (int t = 0; t < 2; t++) begin
            for (int a = 0; a < 16; a++) m_valid[t][a] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        ready_i = 1'b1;
        reset_outputs_low();
        fill_both_slots();
        write_and_read_back();
        rewrite_present_key();
        delete_and_miss();
        random_ops_with_stalls();
        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("results left over at the end of the run");
            fail_now();
        end
    end

endmodule

/* tb.f */
hw/hash_pkg.sv
hw/h3_hash.sv
hw/bucket_ram.sv
hw/op_pipe.sv
hw/forward_unit.sv
hw/hash_controller.sv
hw/hash_table.sv
bench/hash_table_sva.sv
bench/tb_hash_table.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hash_table
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	-./$(BUILD_DIR)/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
